// File: rtl/jpegls_ctx_pkg.sv
`default_nettype none

package jpegls_ctx_pkg;

	// image geometry, kept small so a full sweep simulates quickly
	localparam int PIXEL_BITS = 8;
	localparam int IMG_COLS   = 6;
	localparam int IMG_ROWS   = 3;
	localparam int IMG_PLANES = 2;

	typedef logic [PIXEL_BITS-1:0] pixel_t;

	// position counters, 3 bits covers every constant above
	typedef logic [2:0] col_idx_t;
	typedef logic [2:0] row_idx_t;
	typedef logic [2:0] plane_idx_t;

	// one-hot line memory select
	// bit 0 is memory one, bit 1 is memory two, zero means no read
	typedef logic [1:0] bank_sel_t;

	// read request to both line memories
	typedef struct packed {
		bank_sel_t cur_bank;
		col_idx_t  cur_col;
		bank_sel_t prev_bank;
		col_idx_t  prev_col;
	} mem_read_t;

	// position flags of one pixel step, rows counted within the plane
	typedef struct packed {
		logic first_col;
		logic last_col;
		logic first_row;
		logic second_row;
		logic last_of_row;
		logic last_of_sweep;
	} step_tag_t;

	// x is the current pixel, a left, b above, c above-left, d above-right
	typedef struct packed {
		pixel_t x;
		pixel_t a;
		pixel_t b;
		pixel_t c;
		pixel_t d;
	} context_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_PRIME,
		SCAN_STREAM
	} scan_state_t;

endpackage

`default_nettype wire

// File: rtl/scan_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer
	import jpegls_ctx_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	output mem_read_t mem_rd,
	output logic      prime,
	output logic      shift,
	output step_tag_t tag
);

	scan_state_t state;
	col_idx_t    col;
	row_idx_t    row;
	plane_idx_t  plane;
	// global row parity, selects which memory holds the current row
	logic        parity;

	logic      last_col;
	logic      last_row;
	logic      last_plane;
	bank_sel_t cur_sel;
	bank_sel_t prev_sel;

	assign last_col   = (col == col_idx_t'(IMG_COLS - 1));
	assign last_row   = (row == row_idx_t'(IMG_ROWS - 1));
	assign last_plane = (plane == plane_idx_t'(IMG_PLANES - 1));

	// even rows live in memory one, odd rows in memory two
	assign cur_sel  = parity ? 2'b10 : 2'b01;
	// previous row sits in the other memory
	assign prev_sel = parity ? 2'b01 : 2'b10;

	// position flags for the step being read this cycle
	always_comb begin
		tag.first_col     = (col == '0);
		tag.last_col      = last_col;
		tag.first_row     = (row == '0);
		tag.second_row    = (row == row_idx_t'(1));
		tag.last_of_row   = last_col;
		tag.last_of_sweep = last_col & last_row & last_plane;
	end

	// read strobes and window strobes
	always_comb begin
		mem_rd          = '0;
		mem_rd.cur_col  = col;
		mem_rd.prev_col = col;
		prime           = 1'b0;
		shift           = 1'b0;
		case (state)
			SCAN_PRIME: begin
				// fetch column 0 of the row above into d
				prime = 1'b1;
				// row 0 has nothing above, the cycle is still spent
				if (row != '0) begin
					mem_rd.prev_bank = prev_sel;
				end
			end
			SCAN_STREAM: begin
				shift           = 1'b1;
				mem_rd.cur_bank = cur_sel;
				// above-right pixel runs one column ahead
				mem_rd.prev_col = col + col_idx_t'(1);
				if (row != '0 && !last_col) begin
					mem_rd.prev_bank = prev_sel;
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= SCAN_IDLE;
			col    <= '0;
			row    <= '0;
			plane  <= '0;
			parity <= 1'b0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (start) begin
						state  <= SCAN_PRIME;
						col    <= '0;
						row    <= '0;
						plane  <= '0;
						parity <= 1'b0;
					end
				end
				SCAN_PRIME: begin
					state <= SCAN_STREAM;
				end
				SCAN_STREAM: begin
					if (!last_col) begin
						col <= col + col_idx_t'(1);
					end else begin
						// row done, next row goes to the other memory
						col    <= '0;
						parity <= ~parity;
						state  <= SCAN_PRIME;
						if (!last_row) begin
							row <= row + row_idx_t'(1);
						end else begin
							row <= '0;
							if (last_plane) begin
								// end of sweep, wait for the next start
								state <= SCAN_IDLE;
								plane <= '0;
							end else begin
								plane <= plane + plane_idx_t'(1);
							end
						end
					end
				end
				default: begin
					state <= SCAN_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/neighbor_window.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_window
	import jpegls_ctx_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      prime,
	input  logic      shift,
	input  step_tag_t tag_in,
	input  pixel_t    pixel_in,
	input  pixel_t    prev_pixel_in,
	output context_t  window,
	output pixel_t    row_start,
	output logic      valid,
	output step_tag_t tag_out
);

	// strobes and tag delayed to line up with the memory data
	logic      pend_prime;
	logic      pend_shift;
	step_tag_t pend_tag;
	// column-0 above pixel of the current row
	pixel_t    saved_start;

	always_ff @(posedge clk) begin
		if (reset) begin
			pend_prime <= 1'b0;
			pend_shift <= 1'b0;
			valid      <= 1'b0;
		end else begin
			pend_prime <= prime;
			pend_shift <= shift;
			valid      <= pend_shift;
		end
	end

	always_ff @(posedge clk) begin
		pend_tag <= tag_in;
		// prime return seeds d with column 0 of the row above
		if (pend_prime) begin
			window.d <= prev_pixel_in;
		end
		if (pend_shift) begin
			window.x <= pixel_in;
			window.a <= window.x;
			window.b <= window.d;
			window.c <= window.b;
			window.d <= prev_pixel_in;
			tag_out  <= pend_tag;
			// new b at column 0 is kept for c two rows on
			if (pend_tag.first_col) begin
				saved_start <= window.d;
				row_start   <= saved_start;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/context_emitter.sv
`timescale 1ns/1ps
`default_nettype none

module context_emitter
	import jpegls_ctx_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  context_t  window,
	input  pixel_t    row_start,
	input  logic      valid,
	input  step_tag_t tag,
	output context_t  ctx,
	output logic      start_enc,
	output logic      eol,
	output logic      eof
);

	context_t fixed;

	// JPEG-LS edge substitutions on the raw window
	always_comb begin
		fixed = window;
		// nothing above row 0 of a plane
		if (tag.first_row) begin
			fixed.b = '0;
			fixed.c = '0;
			fixed.d = '0;
		end
		if (tag.first_col) begin
			// left neighbour falls back to the pixel above
			fixed.a = fixed.b;
			// above-left becomes column 0 from two rows up, zero in row 1
			if (!tag.first_row) begin
				fixed.c = tag.second_row ? '0 : row_start;
			end
		end
		// no pixel right of the last column
		if (tag.last_col) begin
			fixed.d = fixed.b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start_enc <= 1'b0;
			eol       <= 1'b0;
			eof       <= 1'b0;
		end else begin
			start_enc <= valid;
			eol       <= valid & tag.last_of_row;
			eof       <= valid & tag.last_of_sweep;
		end
	end

	// context is held between pulses
	always_ff @(posedge clk) begin
		if (valid) begin
			ctx <= fixed;
		end
	end

endmodule

`default_nettype wire

// File: rtl/jpegls_context_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module jpegls_context_fetch
	import jpegls_ctx_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  pixel_t    pixel_in,
	input  pixel_t    prev_pixel_in,
	output mem_read_t mem_rd,
	output context_t  ctx,
	output logic      start_enc,
	output logic      eol,
	output logic      eof
);

	logic      prime;
	logic      shift;
	step_tag_t seq_tag;
	context_t  raw_window;
	pixel_t    row_start;
	logic      win_valid;
	step_tag_t win_tag;

	// counters, state and memory strobes
	scan_sequencer u_sequencer (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.mem_rd (mem_rd),
		.prime  (prime),
		.shift  (shift),
		.tag    (seq_tag)
	);

	// returned pixels into the x, a, b, c, d registers
	neighbor_window u_window (
		.clk           (clk),
		.reset         (reset),
		.prime         (prime),
		.shift         (shift),
		.tag_in        (seq_tag),
		.pixel_in      (pixel_in),
		.prev_pixel_in (prev_pixel_in),
		.window        (raw_window),
		.row_start     (row_start),
		.valid         (win_valid),
		.tag_out       (win_tag)
	);

	// edge rules and output register
	context_emitter u_emitter (
		.clk       (clk),
		.reset     (reset),
		.window    (raw_window),
		.row_start (row_start),
		.valid     (win_valid),
		.tag       (win_tag),
		.ctx       (ctx),
		.start_enc (start_enc),
		.eol       (eol),
		.eof       (eof)
	);

endmodule

`default_nettype wire

// File: verification/tb_jpegls_context_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jpegls_context_fetch
	import jpegls_ctx_pkg::*;
();

	localparam int TOTAL_ROWS   = IMG_PLANES * IMG_ROWS;
	localparam int TOTAL_PIX    = TOTAL_ROWS * IMG_COLS;
	localparam int SWEEP_CYCLES = TOTAL_ROWS * (IMG_COLS + 1);
	localparam int CYCLE_LIMIT  = 4 * SWEEP_CYCLES + 100;
	// line memory output when no read was strobed
	localparam pixel_t NO_DATA  = 8'h5a;

	logic      clk = 1'b0;
	logic      reset;
	logic      start;
	pixel_t    pixel_in = '0;
	pixel_t    prev_pixel_in = '0;
	mem_read_t mem_rd;
	context_t  ctx;
	logic      start_enc;
	logic      eol;
	logic      eof;

	// image in raster order, global row g holds pixels g*IMG_COLS onwards
	pixel_t    image [0:TOTAL_PIX-1];
	// expected read request per cycle of a sweep, prime first in each row
	mem_read_t exp_reads [$];
	mem_read_t seen_req = '0;
	logic      seen_start = 1'b0;
	// global row whose pixels the current-row reads return
	int        mem_row = 0;
	int        pulse_count = TOTAL_PIX;
	int        cycles = 0;

	jpegls_context_fetch DUT (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.pixel_in      (pixel_in),
		.prev_pixel_in (prev_pixel_in),
		.mem_rd        (mem_rd),
		.ctx           (ctx),
		.start_enc     (start_enc),
		.eol           (eol),
		.eof           (eof)
	);

	always #4 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	function automatic pixel_t pix(input int g, input int k);
		return image[g * IMG_COLS + k];
	endfunction

	// even global rows sit in memory one, odd rows in memory two
	function automatic bank_sel_t row_bank(input int g);
		return (g % 2 == 0) ? 2'b01 : 2'b10;
	endfunction

	function automatic bank_sel_t other_bank(input int g);
		return (g % 2 == 0) ? 2'b10 : 2'b01;
	endfunction

	// column fields mean nothing without a bank strobe
	function automatic mem_read_t tidy_read(input mem_read_t r);
		mem_read_t t;
		t = r;
		if (t.cur_bank == 2'b00)
			t.cur_col = '0;
		if (t.prev_bank == 2'b00)
			t.prev_col = '0;
		return t;
	endfunction

	// memory one holds the newest even row, memory two the newest odd row
	function automatic pixel_t bank_pixel(input bank_sel_t bank, input col_idx_t col);
		int g;
		int k;
		k = int'(col);
		if (bank == 2'b01)
			g = (mem_row % 2 == 0) ? mem_row : mem_row - 1;
		else if (bank == 2'b10)
			g = (mem_row % 2 == 1) ? mem_row : mem_row - 1;
		else
			return NO_DATA;
		if (g < 0 || g >= TOTAL_ROWS || k >= IMG_COLS)
			return NO_DATA;
		return pix(g, k);
	endfunction

	// JPEG-LS neighbours of raster pixel n with the edge rules
	function automatic context_t ref_context(input int n);
		context_t e;
		int g;
		int k;
		int r;
		g = n / IMG_COLS;
		k = n % IMG_COLS;
		r = g % IMG_ROWS;
		e = '0;
		e.x = pix(g, k);
		if (r != 0) begin
			e.b = pix(g - 1, k);
			// column 0 takes c from two rows up, none in row 1
			if (k == 0)
				e.c = (r == 1) ? pixel_t'(0) : pix(g - 2, 0);
			else
				e.c = pix(g - 1, k - 1);
			e.d = (k == IMG_COLS - 1) ? e.b : pix(g - 1, k + 1);
		end
		e.a = (k == 0) ? e.b : pix(g, k - 1);
		return e;
	endfunction

	// one prime then IMG_COLS stream reads per row, no gaps
	task automatic plan_reads();
		mem_read_t e;
		int g;
		int k;
		exp_reads.delete();
		for (g = 0; g < TOTAL_ROWS; g++) begin
			e = '0;
			if (g % IMG_ROWS != 0)
				e.prev_bank = other_bank(g);
			exp_reads.push_back(e);
			for (k = 0; k < IMG_COLS; k++) begin
				e = '0;
				e.cur_bank = row_bank(g);
				e.cur_col  = col_idx_t'(k);
				if (g % IMG_ROWS != 0 && k != IMG_COLS - 1) begin
					e.prev_bank = other_bank(g);
					e.prev_col  = col_idx_t'(k + 1);
				end
				exp_reads.push_back(e);
			end
		end
	endtask

	task automatic check_read(input mem_read_t got, input mem_read_t want);
		if (tidy_read(got) !== want)
			stop_run($sformatf("error: mem_rd got %h expected %h", got, want));
	endtask

	task automatic check_context(input context_t got, input context_t want, input int n);
		if (got.x !== want.x)
			stop_run($sformatf("error: ctx.x got %h expected %h at pixel %0d", got.x, want.x, n));
		else if (got.a !== want.a)
			stop_run($sformatf("error: ctx.a got %h expected %h at pixel %0d", got.a, want.a, n));
		else if (got.b !== want.b)
			stop_run($sformatf("error: ctx.b got %h expected %h at pixel %0d", got.b, want.b, n));
		else if (got.c !== want.c)
			stop_run($sformatf("error: ctx.c got %h expected %h at pixel %0d", got.c, want.c, n));
		else if (got.d !== want.d)
			stop_run($sformatf("error: ctx.d got %h expected %h at pixel %0d", got.d, want.d, n));
	endtask

	task automatic check_markers(input logic got_eol, input logic got_eof,
			input logic want_eol, input logic want_eof, input int n);
		if (got_eol !== want_eol)
			stop_run($sformatf("error: eol got %h expected %h at pixel %0d", got_eol, want_eol, n));
		else if (got_eof !== want_eof)
			stop_run($sformatf("error: eof got %h expected %h at pixel %0d", got_eof, want_eof, n));
	endtask

	// line memory model, request seen mid-cycle, data one cycle later
	always @(negedge clk) begin
		seen_req   = mem_rd;
		seen_start = start;
	end

	always @(posedge clk) begin
		#1;
		if (seen_start)
			mem_row = 0;
		pixel_in      = bank_pixel(seen_req.cur_bank, seen_req.cur_col);
		prev_pixel_in = bank_pixel(seen_req.prev_bank, seen_req.prev_col);
		// last column read done, the next row becomes current
		if (seen_req.cur_bank != 2'b00 && seen_req.cur_col == col_idx_t'(IMG_COLS - 1))
			mem_row = mem_row + 1;
	end

	// outputs sampled on the falling edge where they are stable
	always @(negedge clk) begin : monitor
		mem_read_t want;
		if (!reset) begin
			if (exp_reads.size() > 0)
				want = exp_reads.pop_front();
			else
				want = '0;
			check_read(mem_rd, want);
			if (start_enc) begin
				if (pulse_count >= TOTAL_PIX)
					stop_run("start_enc pulsed while no sweep was running");
				check_context(ctx, ref_context(pulse_count), pulse_count);
				check_markers(eol, eof, (pulse_count % IMG_COLS) == IMG_COLS - 1,
					pulse_count == TOTAL_PIX - 1, pulse_count);
				pulse_count = pulse_count + 1;
			end else begin
				check_markers(eol, eof, 1'b0, 1'b0, pulse_count);
			end
			// start seen in idle, prime follows next cycle
			if (start) begin
				plan_reads();
				pulse_count = 0;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			stop_run($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// random idle gap, one start pulse, then wait for the last pixel
	task automatic run_sweep();
		int unsigned idle;
		idle = 3 + ($urandom % 6);
		repeat (idle) @(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		while (pulse_count < TOTAL_PIX)
			@(posedge clk);
	endtask

	initial begin
		void'($urandom(60117));
		$readmemh("verification/jpegls_image_vectors.hex", image);
		reset = 1'b1;
		start = 1'b0;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		run_sweep();
		// second sweep must give the same contexts
		run_sweep();
		repeat (10) @(posedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/jpegls_image_vectors.hex
// one pixel per line in hex, raster order
// plane 0 rows 0 to 2, then plane 1 rows 0 to 2, six pixels per row
12
34
56
78
9a
bc
21
43
65
87
a9
cb
3c
5e
7f
91
b3
d5
e1
c2
a3
84
65
46
17
28
39
4a
6b
7c
8d
9e
af
b0
c1
d2

// File: jpegls_context_fetch.f
rtl/jpegls_ctx_pkg.sv
rtl/scan_sequencer.sv
rtl/neighbor_window.sv
rtl/context_emitter.sv
rtl/jpegls_context_fetch.sv
verification/tb_jpegls_context_fetch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_jpegls_context_fetch
FILELIST  ?= jpegls_context_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
